/* Makefile */
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module nettlp_cmd_tb \
		-f files.f -o nettlp_cmd_sim
	./obj_dir/nettlp_cmd_sim | tee $(LOG)
	grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* files.f */
logic/nettlp_cmd_pkg.sv
logic/cmd_fifo.sv
logic/nettlp_cmd_core.sv
logic/nettlp_cmd_top.sv
test/nettlp_cmd_properties.sv
test/nettlp_cmd_tb.sv

/* logic/cmd_fifo.sv */
`timescale 1ns/100ps
`default_nettype none

module cmd_fifo
	import nettlp_cmd_pkg::*;
#(
	parameter int depth_log2 = 3
) (
	input wire clk,
	input wire rst,

	input wire wr_en,
	input wire fifo_cmd_t din,
	output logic full,

	input wire rd_en,
	output fifo_cmd_t dout,
	output logic empty
);

fifo_cmd_t mem [0:(1 << depth_log2) - 1];
logic [depth_log2-1:0] wr_ptr;
logic [depth_log2-1:0] rd_ptr;
logic [depth_log2:0] count;
logic [depth_log2:0] count_next;
logic do_wr;
logic do_rd;

assign do_wr = wr_en && !full;
assign do_rd = rd_en && !empty;
assign dout = mem[rd_ptr]; // Head word falls through.

always_comb begin
	count_next = count;
	if (do_wr && !do_rd)
		count_next = count + 1'b1;
	else if (do_rd && !do_wr)
		count_next = count - 1'b1;
end

always_ff @(posedge clk) begin
	if (do_wr)
		mem[wr_ptr] <= din;
end

always_ff @(posedge clk) begin
	if (rst) begin
		wr_ptr <= '0;
		rd_ptr <= '0;
		count <= '0;
		full <= 1'b0;
		empty <= 1'b1;
	end else begin
		if (do_wr)
			wr_ptr <= wr_ptr + 1'b1;
		if (do_rd)
			rd_ptr <= rd_ptr + 1'b1;
		count <= count_next;
		full <= count_next[depth_log2]; // Top bit only set at full depth.
		empty <= (count_next == '0);
	end
end

endmodule

`default_nettype wire

/* logic/nettlp_cmd_core.sv */
`timescale 1ns/100ps
`default_nettype none

module nettlp_cmd_core
	import nettlp_cmd_pkg::*;
(
	input wire clk,
	input wire rst,

	// Command side.
	output logic cmd_rd_en,
	input wire cmd_empty,
	input wire fifo_cmd_t cmd_dout,

	// Reply side.
	output logic reply_wr_en,
	input wire reply_full,
	output fifo_cmd_t reply_din,

	output adapter_regs_t regs
);

typedef enum logic [2:0] {
	IDLE,
	DECODE_READ,
	DECODE_WRITE,
	SEND,
	BUBBLE,
	APPLY
} state_t;

state_t state;
fifo_cmd_t cmd;
logic [2:0] bubble_cnt;
logic capture;
logic addr_ok;
reg_data_t rd_data;
reg_data_t wr_data;

function automatic reg_data_t swap32(input reg_data_t d);
	return {d[7:0], d[15:8], d[23:16], d[31:24]};
endfunction

// Guard against the cycle in which the pop is still in flight.
assign capture = (state == IDLE) && !cmd_empty && !cmd_rd_en;

assign wr_data = swap32(cmd.pkt.data);

// Register read mux, already in network order.
always_comb begin
	addr_ok = 1'b1;
	rd_data = '0;
	case (cmd.pkt.dwaddr)
		ADAPTER_REG_MAGIC:
			rd_data = swap32(regs.magic);
		ADAPTER_REG_DSTMAC_LOW:
			rd_data = swap32(regs.dstmac[31:0]);
		ADAPTER_REG_DSTMAC_HIGH:
			rd_data = swap32({16'h0, regs.dstmac[47:32]}); // Upper two bytes only.
		ADAPTER_REG_SRCMAC_LOW:
			rd_data = swap32(regs.srcmac[31:0]);
		ADAPTER_REG_SRCMAC_HIGH:
			rd_data = swap32({16'h0, regs.srcmac[47:32]});
		ADAPTER_REG_DSTIP:
			rd_data = swap32(regs.dstip);
		ADAPTER_REG_SRCIP:
			rd_data = swap32(regs.srcip);
		ADAPTER_REG_DSTPORT:
			rd_data = swap32({16'h0, regs.dstport});
		ADAPTER_REG_SRCPORT:
			rd_data = swap32({16'h0, regs.srcport});
		default:
			addr_ok = 1'b0;
	endcase
end

// Captured command, turned into the reply in place.
always_ff @(posedge clk) begin
	if (capture) begin
		cmd <= cmd_dout;
	end else if (state == DECODE_READ) begin
		cmd.pkt.udp_check <= '0; // No checksum.
		cmd.pkt.data <= rd_data;
	end
end

always_comb begin
	reply_wr_en = 1'b0;
	reply_din = '0;
	if (state == SEND && !reply_full) begin
		reply_wr_en = 1'b1;
		reply_din = cmd;
	end else if (state == BUBBLE && !reply_full) begin
		reply_wr_en = 1'b1; // Zero word.
	end
end

always_ff @(posedge clk) begin
	if (rst) begin
		state <= IDLE;
		cmd_rd_en <= 1'b0;
		bubble_cnt <= '0;
		regs <= ADAPTER_REGS_RESET;
	end else begin
		cmd_rd_en <= 1'b0;

		case (state)
			IDLE: begin
				if (capture) begin
					cmd_rd_en <= 1'b1;
					if (cmd_dout.data_valid) begin
						if (cmd_dout.pkt.opcode == NETTLP_OPC_REG_RD)
							state <= DECODE_READ;
						else if (cmd_dout.pkt.opcode == NETTLP_OPC_REG_WR)
							state <= DECODE_WRITE;
					end
				end
			end
			DECODE_READ: begin
				bubble_cnt <= '0;
				state <= addr_ok ? SEND : IDLE;
			end
			DECODE_WRITE: begin
				state <= addr_ok ? APPLY : IDLE;
			end
			SEND: begin
				if (!reply_full)
					state <= BUBBLE;
			end
			BUBBLE: begin
				if (!reply_full) begin
					bubble_cnt <= bubble_cnt + 1'b1;
					if (bubble_cnt == 3'(BUBBLE_WORDS - 1))
						state <= IDLE;
				end
			end
			APPLY: begin
				state <= IDLE;
				case (cmd.pkt.dwaddr)
					ADAPTER_REG_DSTMAC_LOW:
						regs.dstmac[31:0] <= wr_data;
					ADAPTER_REG_DSTMAC_HIGH:
						regs.dstmac[47:32] <= wr_data[15:0];
					ADAPTER_REG_SRCMAC_LOW:
						regs.srcmac[31:0] <= wr_data;
					ADAPTER_REG_SRCMAC_HIGH:
						regs.srcmac[47:32] <= wr_data[15:0];
					ADAPTER_REG_DSTIP:
						regs.dstip <= wr_data;
					ADAPTER_REG_SRCIP:
						regs.srcip <= wr_data;
					ADAPTER_REG_DSTPORT:
						regs.dstport <= wr_data[15:0];
					ADAPTER_REG_SRCPORT:
						regs.srcport <= wr_data[15:0];
					default: begin
						// Magic is read-only.
					end
				endcase
			end
			default: begin
				state <= IDLE;
			end
		endcase
	end
end

endmodule

`default_nettype wire

/* logic/nettlp_cmd_pkg.sv */
`default_nettype none

package nettlp_cmd_pkg;

	typedef logic [7:0] opcode_t;
	typedef logic [7:0] dwaddr_t;
	typedef logic [31:0] reg_data_t;
	typedef logic [47:0] mac_t;
	typedef logic [31:0] ip_t;
	typedef logic [15:0] port_t;

	// Command payload as carried in the UDP datagram.
	typedef struct packed {
		logic [15:0] udp_check;
		opcode_t opcode;
		dwaddr_t dwaddr;
		reg_data_t data; // Network byte order.
	} cmd_pkt_t;

	typedef struct packed {
		logic data_valid;
		cmd_pkt_t pkt;
	} fifo_cmd_t;

	typedef struct packed {
		reg_data_t magic;
		mac_t dstmac;
		mac_t srcmac;
		ip_t dstip;
		ip_t srcip;
		port_t dstport;
		port_t srcport;
	} adapter_regs_t;

	localparam opcode_t NETTLP_OPC_REG_RD = 8'h01;
	localparam opcode_t NETTLP_OPC_REG_WR = 8'h02;

	localparam dwaddr_t ADAPTER_REG_MAGIC = 8'd0;
	localparam dwaddr_t ADAPTER_REG_DSTMAC_LOW = 8'd1;
	localparam dwaddr_t ADAPTER_REG_DSTMAC_HIGH = 8'd2;
	localparam dwaddr_t ADAPTER_REG_SRCMAC_LOW = 8'd3;
	localparam dwaddr_t ADAPTER_REG_SRCMAC_HIGH = 8'd4;
	localparam dwaddr_t ADAPTER_REG_DSTIP = 8'd5;
	localparam dwaddr_t ADAPTER_REG_SRCIP = 8'd6;
	localparam dwaddr_t ADAPTER_REG_DSTPORT = 8'd7;
	localparam dwaddr_t ADAPTER_REG_SRCPORT = 8'd8;

	localparam adapter_regs_t ADAPTER_REGS_RESET = '{
		magic: 32'h01_23_45_67,
		dstmac: 48'hff_ff_ff_ff_ff_ff,
		srcmac: 48'h00_11_22_33_44_55,
		dstip: {8'd192, 8'd168, 8'd10, 8'd3},
		srcip: {8'd192, 8'd168, 8'd10, 8'd1},
		dstport: 16'h3776,
		srcport: 16'h3776
	};

	localparam int BUBBLE_WORDS = 5; // Zero words after each reply.

	localparam int CMD_FIFO_DEPTH_LOG2 = 3;
	localparam int REPLY_FIFO_DEPTH_LOG2 = 4;

endpackage

`default_nettype wire

/* logic/nettlp_cmd_top.sv */
`timescale 1ns/100ps
`default_nettype none

module nettlp_cmd_top
	import nettlp_cmd_pkg::*;
(
	input wire clk,
	input wire rst,

	input wire cmd_wr_en,
	input wire fifo_cmd_t cmd_din,
	output logic cmd_full,

	input wire reply_rd_en,
	output fifo_cmd_t reply_dout,
	output logic reply_empty,

	output adapter_regs_t regs
);

logic cmd_rd_en;
logic cmd_empty;
fifo_cmd_t cmd_dout;
logic reply_wr_en;
logic reply_full;
fifo_cmd_t reply_din;

cmd_fifo #(
	.depth_log2(CMD_FIFO_DEPTH_LOG2)
) cmd_fifo_i (
	.clk(clk),
	.rst(rst),
	.wr_en(cmd_wr_en),
	.din(cmd_din),
	.full(cmd_full),
	.rd_en(cmd_rd_en),
	.dout(cmd_dout),
	.empty(cmd_empty)
);

nettlp_cmd_core nettlp_cmd_core_i (
	.clk(clk),
	.rst(rst),
	.cmd_rd_en(cmd_rd_en),
	.cmd_empty(cmd_empty),
	.cmd_dout(cmd_dout),
	.reply_wr_en(reply_wr_en),
	.reply_full(reply_full),
	.reply_din(reply_din),
	.regs(regs)
);

// Holds a reply and its bubbles for the network side.
cmd_fifo #(
	.depth_log2(REPLY_FIFO_DEPTH_LOG2)
) reply_fifo_i (
	.clk(clk),
	.rst(rst),
	.wr_en(reply_wr_en),
	.din(reply_din),
	.full(reply_full),
	.rd_en(reply_rd_en),
	.dout(reply_dout),
	.empty(reply_empty)
);

endmodule

`default_nettype wire

/* test/nettlp_cmd_properties.sv */
`timescale 1ns/100ps
`default_nettype none

module nettlp_cmd_properties
	import nettlp_cmd_pkg::*;
(
	input wire clk,
	input wire rst,
	input wire cmd_rd_en,
	input wire cmd_empty,
	input wire reply_wr_en,
	input wire reply_full,
	input wire adapter_regs_t regs
);

no_write_when_full: assert property (@(posedge clk) disable iff (rst)
	!(reply_wr_en && reply_full))
	else $error("Reply written while the reply FIFO is full.");

no_pop_when_empty: assert property (@(posedge clk) disable iff (rst)
	!(cmd_rd_en && cmd_empty))
	else $error("Command popped from an empty FIFO.");

magic_constant: assert property (@(posedge clk) disable iff (rst)
	$stable(regs.magic))
	else $error("Magic register changed after reset.");

endmodule

bind nettlp_cmd_core nettlp_cmd_properties nettlp_cmd_properties_i (
	.clk(clk),
	.rst(rst),
	.cmd_rd_en(cmd_rd_en),
	.cmd_empty(cmd_empty),
	.reply_wr_en(reply_wr_en),
	.reply_full(reply_full),
	.regs(regs)
);

`default_nettype wire

/* test/nettlp_cmd_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module nettlp_cmd_tb
	import nettlp_cmd_pkg::*;
();

logic clk;
logic rst;
logic cmd_wr_en;
fifo_cmd_t cmd_din;
logic cmd_full;
logic reply_rd_en;
fifo_cmd_t reply_dout;
logic reply_empty;
adapter_regs_t regs;

adapter_regs_t model; // Expected register contents.

nettlp_cmd_top nettlp_cmd_top_i (
	.clk(clk),
	.rst(rst),
	.cmd_wr_en(cmd_wr_en),
	.cmd_din(cmd_din),
	.cmd_full(cmd_full),
	.reply_rd_en(reply_rd_en),
	.reply_dout(reply_dout),
	.reply_empty(reply_empty),
	.regs(regs)
);

always #10 clk = ~clk;

// The four tests need roughly 10 us together.
initial begin
	#20000;
	$display("Simulation timed out before the tests finished");
	$display("CHECKS FAILED");
	$fatal(1);
end

task automatic abort_run(input string msg);
	$display("%s", msg);
	$display("CHECKS FAILED");
	$fatal(1);
endtask

task automatic verify_word(input string test, input fifo_cmd_t exp, input fifo_cmd_t act);
	assert (act === exp)
	else abort_run($sformatf("Fail %s: expected %h, actual %h", test, exp, act));
endtask

task automatic check_regs(input string test, input adapter_regs_t exp, input adapter_regs_t act);
	assert (act === exp)
	else abort_run($sformatf("Fail %s: expected %h, actual %h", test, exp, act));
endtask

// Host order to network order, byte by byte.
function automatic reg_data_t net_order(input reg_data_t v);
	reg_data_t r;
	int i;
	for (i = 0; i < 4; i++)
		r[8*(3-i) +: 8] = v[8*i +: 8];
	return r;
endfunction

function automatic fifo_cmd_t build_cmd(input logic valid, input opcode_t opc,
	input dwaddr_t addr, input reg_data_t data);
	fifo_cmd_t w;
	w.data_valid = valid;
	w.pkt.udp_check = 16'($urandom); // Must come back cleared.
	w.pkt.opcode = opc;
	w.pkt.dwaddr = addr;
	w.pkt.data = data;
	return w;
endfunction

function automatic fifo_cmd_t expected_reply(input dwaddr_t addr);
	fifo_cmd_t w;
	reg_data_t v;
	case (addr)
		ADAPTER_REG_MAGIC: v = model.magic;
		ADAPTER_REG_DSTMAC_LOW: v = model.dstmac[31:0];
		ADAPTER_REG_DSTMAC_HIGH: v = {16'h0, model.dstmac[47:32]};
		ADAPTER_REG_SRCMAC_LOW: v = model.srcmac[31:0];
		ADAPTER_REG_SRCMAC_HIGH: v = {16'h0, model.srcmac[47:32]};
		ADAPTER_REG_DSTIP: v = model.dstip;
		ADAPTER_REG_SRCIP: v = model.srcip;
		ADAPTER_REG_DSTPORT: v = {16'h0, model.dstport};
		ADAPTER_REG_SRCPORT: v = {16'h0, model.srcport};
		default: v = '0;
	endcase
	w = '0;
	w.data_valid = 1'b1;
	w.pkt.opcode = NETTLP_OPC_REG_RD;
	w.pkt.dwaddr = addr;
	w.pkt.data = net_order(v);
	return w;
endfunction

task automatic apply_write(input dwaddr_t addr, input reg_data_t data);
	reg_data_t v;
	v = net_order(data); // Reversal undoes itself.
	case (addr)
		ADAPTER_REG_DSTMAC_LOW: model.dstmac[31:0] = v;
		ADAPTER_REG_DSTMAC_HIGH: model.dstmac[47:32] = v[15:0];
		ADAPTER_REG_SRCMAC_LOW: model.srcmac[31:0] = v;
		ADAPTER_REG_SRCMAC_HIGH: model.srcmac[47:32] = v[15:0];
		ADAPTER_REG_DSTIP: model.dstip = v;
		ADAPTER_REG_SRCIP: model.srcip = v;
		ADAPTER_REG_DSTPORT: model.dstport = v[15:0];
		ADAPTER_REG_SRCPORT: model.srcport = v[15:0];
		default: ;
	endcase
endtask

task automatic push_cmd(input fifo_cmd_t w);
	int n;
	n = 0;
	while (cmd_full && n < 200) begin
		@(negedge clk);
		n++;
	end
	assert (!cmd_full) else abort_run("Command FIFO stayed full, push not possible");
	cmd_din = w;
	cmd_wr_en = 1'b1;
	@(negedge clk);
	cmd_wr_en = 1'b0;
endtask

task automatic pop_reply(output fifo_cmd_t w);
	int n;
	n = 0;
	while (reply_empty && n < 100) begin
		@(negedge clk);
		n++;
	end
	assert (!reply_empty) else abort_run("No reply word arrived in time");
	w = reply_dout;
	reply_rd_en = 1'b1;
	@(negedge clk);
	reply_rd_en = 1'b0;
endtask

// A reply and its trailing bubbles.
task automatic expect_reply(input string test, input dwaddr_t addr);
	fifo_cmd_t w;
	int i;
	pop_reply(w);
	verify_word(test, expected_reply(addr), w);
	for (i = 0; i < BUBBLE_WORDS; i++) begin
		pop_reply(w);
		verify_word("bubbles", '0, w);
	end
endtask

task automatic read_reg(input string test, input dwaddr_t addr);
	push_cmd(build_cmd(1'b1, NETTLP_OPC_REG_RD, addr, $urandom));
	expect_reply(test, addr);
endtask

task automatic reset_values();
	int a;
	check_regs("reset values", ADAPTER_REGS_RESET, regs);
	for (a = 0; a < 9; a++)
		read_reg("reset values", dwaddr_t'(a));
endtask

task automatic register_writes();
	int a;
	reg_data_t d;
	for (a = 1; a < 9; a++) begin
		d = $urandom;
		push_cmd(build_cmd(1'b1, NETTLP_OPC_REG_WR, dwaddr_t'(a), d));
		apply_write(dwaddr_t'(a), d);
		read_reg("writes", dwaddr_t'(a)); // Write is done once this returns.
		check_regs("writes", model, regs);
	end
	push_cmd(build_cmd(1'b1, NETTLP_OPC_REG_WR, ADAPTER_REG_MAGIC, $urandom));
	read_reg("magic write", ADAPTER_REG_MAGIC);
	check_regs("magic write", model, regs);
endtask

task automatic dropped_commands();
	push_cmd(build_cmd(1'b0, NETTLP_OPC_REG_RD, ADAPTER_REG_DSTIP, $urandom));
	push_cmd(build_cmd(1'b0, NETTLP_OPC_REG_WR, ADAPTER_REG_DSTIP, $urandom));
	push_cmd(build_cmd(1'b1, 8'h7f, ADAPTER_REG_DSTIP, $urandom));
	push_cmd(build_cmd(1'b1, NETTLP_OPC_REG_RD, 8'd9, $urandom));
	push_cmd(build_cmd(1'b1, NETTLP_OPC_REG_WR, 8'd9, $urandom));
	read_reg("drops", ADAPTER_REG_DSTIP); // First word out must be this reply.
	assert (reply_empty) else abort_run("Unexpected reply word after dropped commands");
	check_regs("drops", model, regs);
endtask

task automatic back_pressure();
	dwaddr_t addrs [4];
	int i;
	int n;
	addrs = '{ADAPTER_REG_DSTMAC_HIGH, ADAPTER_REG_SRCIP, ADAPTER_REG_DSTPORT,
		ADAPTER_REG_MAGIC};
	for (i = 0; i < 4; i++)
		push_cmd(build_cmd(1'b1, NETTLP_OPC_REG_RD, addrs[i], $urandom));
	n = 0;
	while (!nettlp_cmd_top_i.reply_full && n < 100) begin
		@(negedge clk);
		n++;
	end
	assert (nettlp_cmd_top_i.reply_full)
	else abort_run("Reply FIFO never filled while reads were held back");
	// Stalled core lets the command FIFO fill up.
	for (i = 0; i < 16 && !cmd_full; i++)
		push_cmd(build_cmd(1'b0, NETTLP_OPC_REG_RD, ADAPTER_REG_MAGIC, $urandom));
	assert (cmd_full) else abort_run("Command FIFO never filled while the core was stalled");
	for (i = 0; i < 4; i++)
		expect_reply("back-pressure", addrs[i]);
	assert (reply_empty) else abort_run("Extra words left in the reply FIFO after draining");
endtask

initial begin
	void'($urandom(32'ha405bc4a));
	clk = 1'b0;
	rst = 1'b1;
	cmd_wr_en = 1'b0;
	cmd_din = '0;
	reply_rd_en = 1'b0;
	model = ADAPTER_REGS_RESET;
	repeat (3) @(negedge clk);
	rst = 1'b0;

	reset_values();
	register_writes();
	dropped_commands();
	back_pressure();

	$display("ALL CHECKS PASSED");
	$finish;
end

endmodule

`default_nettype wire
